//--- all.f
+incdir+rtl
rtl/kd_ctrl_pkg.sv
rtl/kd_phase_decode.sv
rtl/kd_load_execute.sv
rtl/kd_best_drain.sv
rtl/kd_ctrl_top.sv
tb/kd_ctrl_tb.sv

//--- Bender.yml
package:
  name: kd_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/kd_ctrl_pkg.sv
      - rtl/kd_phase_decode.sv
      - rtl/kd_load_execute.sv
      - rtl/kd_best_drain.sv
      - rtl/kd_ctrl_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/kd_ctrl_tb.sv

//--- tb/kd_ctrl_tb.sv
`timescale 1ns/1ns
`include "kd_ctrl_cfg.svh"

module kd_ctrl_tb;

    import kd_ctrl_pkg::*;

    localparam int leaf_beats = `KD_NUM_LEAVES * `KD_LEAF_SIZE;
    localparam int load_beats = `KD_NUM_NODES + leaf_beats + `KD_NUM_QUERYS;
    localparam int drain_words = 2 * (`KD_NUM_QUERYS / 2) + 2 * `KD_NUM_QUERYS;
    // two loads and one send
    localparam int wd_cycles = 8 * (2 * load_beats + drain_words);

    logic         clk;
    logic         rst_n;
    logic         load_kdtree;
    logic         send_best_arr;
    logic         agg_receiver_enq;
    logic         out_fifo_wfull_n;
    logic         agg_receiver_full_n;
    logic         agg_change_fetch_width;
    fetch_width_t agg_input_fetch_width;
    logic         int_node_fsm_enable;
    leaf_lane_t   leaf_mem_csb0;
    leaf_lane_t   leaf_mem_web0;
    leaf_addr_t   leaf_mem_addr0;
    logic         qp_mem_csb0;
    logic         qp_mem_web0;
    qp_addr_t     qp_mem_addr0;
    logic         best_arr_csb1;
    best_addr_t   best_arr_addr1;
    logic         out_fifo_wenq;
    out_sel_e     out_fifo_wdata_sel;

    // reference model state after the last rising edge
    kd_phase_e m_phase;
    int        m_cnt;
    int        m_word;
    logic      m_wenq;
    out_sel_e  m_sel;

    int   errors;
    int   checks;
    int   node_beats;
    int   leaf_writes;
    int   qp_writes;
    int   reads;
    int   sel_cnt [5];
    logic prev_wenq;
    logic [2:0] fw_seen [$];

    kd_ctrl_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int phase_length(input kd_phase_e p);
        case (p)
            load_nodes:           return `KD_NUM_NODES;
            load_leaves:          return leaf_beats;
            load_querys:          return `KD_NUM_QUERYS;
            send_idx0, send_idx1: return `KD_NUM_QUERYS / 2;
            default:              return `KD_NUM_QUERYS;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_reset_values();
        compare_value("leaf_mem_csb0", leaf_mem_csb0, 16'hff);
        compare_value("leaf_mem_web0", leaf_mem_web0, 16'hff);
        compare_value("qp_mem_csb0", qp_mem_csb0, 1);
        compare_value("qp_mem_web0", qp_mem_web0, 1);
        compare_value("best_arr_csb1", best_arr_csb1, 1);
        compare_value("out_fifo_wenq", out_fifo_wenq, 0);
        compare_value("out_fifo_wdata_sel", out_fifo_wdata_sel, 0);
        compare_value("agg_receiver_full_n", agg_receiver_full_n, 0);
        compare_value("agg_change_fetch_width", agg_change_fetch_width, 0);
        compare_value("int_node_fsm_enable", int_node_fsm_enable, 0);
    endtask

    // compare this cycle's outputs with the model, then step the model over the edge
    task automatic model_cycle();
        logic       load_ph;
        logic       dist_ph;
        logic       accept;
        logic       issue;
        logic       rd;
        logic       load_done;
        logic       drain_done;
        logic       fw_pulse;
        logic [2:0] fw;
        logic [7:0] lane_n;
        int         len;
        load_ph = m_phase inside {load_nodes, load_leaves, load_querys};
        dist_ph = m_phase inside {send_dist0, send_dist1};
        len = phase_length(m_phase);
        accept = load_ph && agg_receiver_enq;
        load_done = accept && (m_cnt == len - 1);
        drain_done = m_wenq && (m_word == len - 1);
        issue = (m_phase inside {send_idx0, send_idx1}) || dist_ph;
        issue = issue && !m_wenq && out_fifo_wfull_n;
        rd = issue && !(dist_ph && m_word[0]);
        fw_pulse = 1'b0;
        fw = 3'd0;
        if (m_phase == idle && load_kdtree && !send_best_arr) begin
            fw_pulse = 1'b1;
            fw = `KD_FW_NODES;
        end else if (m_phase == load_nodes && load_done) begin
            fw_pulse = 1'b1;
            fw = `KD_FW_LEAVES;
        end else if (m_phase == load_leaves && load_done) begin
            fw_pulse = 1'b1;
            fw = `KD_FW_QUERYS;
        end
        lane_n = 8'hff;
        if (accept && m_phase == load_leaves) lane_n[m_cnt % `KD_LEAF_SIZE] = 1'b0;

        compare_value("agg_receiver_full_n", agg_receiver_full_n, load_ph);
        compare_value("agg_change_fetch_width", agg_change_fetch_width, fw_pulse);
        compare_value("agg_input_fetch_width", agg_input_fetch_width, fw);
        compare_value("int_node_fsm_enable", int_node_fsm_enable, m_phase == load_nodes);
        compare_value("leaf_mem_csb0", leaf_mem_csb0, lane_n);
        compare_value("leaf_mem_web0", leaf_mem_web0, lane_n);
        if (lane_n != 8'hff)
            compare_value("leaf_mem_addr0", leaf_mem_addr0, m_cnt / `KD_LEAF_SIZE);
        compare_value("qp_mem_csb0", qp_mem_csb0, !(accept && m_phase == load_querys));
        compare_value("qp_mem_web0", qp_mem_web0, !(accept && m_phase == load_querys));
        if (accept && m_phase == load_querys) compare_value("qp_mem_addr0", qp_mem_addr0, m_cnt);
        compare_value("best_arr_csb1", best_arr_csb1, !rd);
        if (rd) compare_value("best_arr_addr1", best_arr_addr1, dist_ph ? m_word / 2 : m_word);
        compare_value("out_fifo_wenq", out_fifo_wenq, m_wenq);
        if (m_wenq) compare_value("out_fifo_wdata_sel", out_fifo_wdata_sel, m_sel);

        if (accept) m_cnt = load_done ? 0 : m_cnt + 1;
        if (m_wenq) m_word = drain_done ? 0 : m_word + 1;
        if (issue) begin
            case (m_phase)
                send_idx0:  m_sel = sel_idx0;
                send_idx1:  m_sel = sel_idx1;
                send_dist0: m_sel = m_word[0] ? sel_dist_hi : sel_dist0;
                default:    m_sel = m_word[0] ? sel_dist_hi : sel_dist1;
            endcase
        end
        m_wenq = issue;
        case (m_phase)
            idle: begin
                if (send_best_arr) m_phase = send_idx0;
                else if (load_kdtree) m_phase = load_nodes;
            end
            load_nodes:  if (load_done) m_phase = load_leaves;
            load_leaves: if (load_done) m_phase = load_querys;
            load_querys: if (load_done) m_phase = idle;
            send_idx0:   if (drain_done) m_phase = send_idx1;
            send_idx1:   if (drain_done) m_phase = send_dist0;
            send_dist0:  if (drain_done) m_phase = send_dist1;
            default:     if (drain_done) m_phase = idle;
        endcase
    endtask

    // per-command totals seen on the DUT ports
    task automatic collect_stats();
        if (agg_change_fetch_width) fw_seen.push_back(agg_input_fetch_width);
        if (agg_receiver_enq && agg_receiver_full_n && int_node_fsm_enable) node_beats++;
        if (leaf_mem_csb0 != 8'hff) leaf_writes++;
        if (!qp_mem_csb0) qp_writes++;
        if (!best_arr_csb1) reads++;
        if (out_fifo_wenq) begin
            assert (!prev_wenq) else begin
                errors++;
                $display("out_fifo_wenq was high in two adjacent cycles at %0t", $time);
            end
            sel_cnt[out_fifo_wdata_sel]++;
        end
        prev_wenq = out_fifo_wenq;
    endtask

    task automatic run_cycle(input logic load_cmd, input logic send_cmd);
        @(negedge clk);
        load_kdtree = load_cmd;
        send_best_arr = send_cmd;
        agg_receiver_enq = ($urandom_range(99) < 50);
        out_fifo_wfull_n = ($urandom_range(99) < 60);
        #5;
        model_cycle();
        collect_stats();
    endtask

    task automatic run_load();
        fw_seen.delete();
        node_beats = 0;
        leaf_writes = 0;
        qp_writes = 0;
        run_cycle(1'b1, 1'b0);
        while (m_phase != idle) run_cycle(1'b0, 1'b0);
        compare_value("fetch_width_pulses", fw_seen.size(), 3);
        if (fw_seen.size() == 3) begin
            compare_value("fetch_width_0", fw_seen[0], `KD_FW_NODES);
            compare_value("fetch_width_1", fw_seen[1], `KD_FW_LEAVES);
            compare_value("fetch_width_2", fw_seen[2], `KD_FW_QUERYS);
        end
        compare_value("node_beats", node_beats, `KD_NUM_NODES);
        compare_value("leaf_writes", leaf_writes, leaf_beats);
        compare_value("qp_writes", qp_writes, `KD_NUM_QUERYS);
    endtask

    task automatic run_send();
        reads = 0;
        foreach (sel_cnt[i]) sel_cnt[i] = 0;
        run_cycle(1'b0, 1'b1);
        while (m_phase != idle) run_cycle(1'b0, 1'b0);
        compare_value("idx0_words", sel_cnt[sel_idx0], `KD_NUM_QUERYS / 2);
        compare_value("idx1_words", sel_cnt[sel_idx1], `KD_NUM_QUERYS / 2);
        compare_value("dist0_lo_words", sel_cnt[sel_dist0], `KD_NUM_QUERYS / 2);
        compare_value("dist1_lo_words", sel_cnt[sel_dist1], `KD_NUM_QUERYS / 2);
        compare_value("dist_hi_words", sel_cnt[sel_dist_hi], `KD_NUM_QUERYS);
        compare_value("best_arr_reads", reads, 2 * `KD_NUM_QUERYS);
    endtask

    initial begin
        void'($urandom(78));
        rst_n = 1'b0;
        load_kdtree = 1'b0;
        send_best_arr = 1'b0;
        agg_receiver_enq = 1'b0;
        out_fifo_wfull_n = 1'b0;
        m_phase = idle;
        m_cnt = 0;
        m_word = 0;
        m_wenq = 1'b0;
        m_sel = sel_idx0;
        errors = 0;
        checks = 0;
        prev_wenq = 1'b0;
        repeat (2) @(negedge clk);
        check_reset_values();
        rst_n = 1'b1;
        repeat (3) run_cycle(1'b0, 1'b0);
        run_load();
        repeat (4) run_cycle(1'b0, 1'b0);
        run_send();
        repeat (4) run_cycle(1'b0, 1'b0);
        run_load();
        repeat (4) run_cycle(1'b0, 1'b0);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", wd_cycles);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- rtl/kd_ctrl_top.sv
`timescale 1ns/1ns

module kd_ctrl_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_kdtree,
    input  logic                      send_best_arr,
    input  logic                      agg_receiver_enq,
    output logic                      agg_receiver_full_n,
    output logic                      agg_change_fetch_width,
    output kd_ctrl_pkg::fetch_width_t agg_input_fetch_width,
    output logic                      int_node_fsm_enable,
    output kd_ctrl_pkg::leaf_lane_t   leaf_mem_csb0,
    output kd_ctrl_pkg::leaf_lane_t   leaf_mem_web0,
    output kd_ctrl_pkg::leaf_addr_t   leaf_mem_addr0,
    output logic                      qp_mem_csb0,
    output logic                      qp_mem_web0,
    output kd_ctrl_pkg::qp_addr_t     qp_mem_addr0,
    output logic                      best_arr_csb1,
    output kd_ctrl_pkg::best_addr_t   best_arr_addr1,
    output logic                      out_fifo_wenq,
    output kd_ctrl_pkg::out_sel_e     out_fifo_wdata_sel,
    input  logic                      out_fifo_wfull_n
);

    import kd_ctrl_pkg::*;

    kd_phase_e phase;
    logic      load_seg_done;
    logic      drain_seg_done;

    kd_phase_decode u_decode (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .load_kdtree            (load_kdtree),
        .send_best_arr          (send_best_arr),
        .load_seg_done          (load_seg_done),
        .drain_seg_done         (drain_seg_done),
        .phase                  (phase),
        .agg_change_fetch_width (agg_change_fetch_width),
        .agg_input_fetch_width  (agg_input_fetch_width)
    );

    kd_load_execute u_execute (
        .clk                 (clk),
        .rst_n               (rst_n),
        .phase               (phase),
        .agg_receiver_enq    (agg_receiver_enq),
        .agg_receiver_full_n (agg_receiver_full_n),
        .int_node_fsm_enable (int_node_fsm_enable),
        .leaf_mem_csb0       (leaf_mem_csb0),
        .leaf_mem_web0       (leaf_mem_web0),
        .leaf_mem_addr0      (leaf_mem_addr0),
        .qp_mem_csb0         (qp_mem_csb0),
        .qp_mem_web0         (qp_mem_web0),
        .qp_mem_addr0        (qp_mem_addr0),
        .load_seg_done       (load_seg_done)
    );

    kd_best_drain u_drain (
        .clk                (clk),
        .rst_n              (rst_n),
        .phase              (phase),
        .out_fifo_wfull_n   (out_fifo_wfull_n),
        .best_arr_csb1      (best_arr_csb1),
        .best_arr_addr1     (best_arr_addr1),
        .out_fifo_wenq      (out_fifo_wenq),
        .out_fifo_wdata_sel (out_fifo_wdata_sel),
        .drain_seg_done     (drain_seg_done)
    );

endmodule

//--- rtl/kd_best_drain.sv
`timescale 1ns/1ns
`include "kd_ctrl_cfg.svh"

module kd_best_drain (
    input  logic                    clk,
    input  logic                    rst_n,
    input  kd_ctrl_pkg::kd_phase_e  phase,
    input  logic                    out_fifo_wfull_n,
    output logic                    best_arr_csb1,
    output kd_ctrl_pkg::best_addr_t best_arr_addr1,
    output logic                    out_fifo_wenq,
    output kd_ctrl_pkg::out_sel_e   out_fifo_wdata_sel,
    output logic                    drain_seg_done
);

    import kd_ctrl_pkg::*;

    localparam beat_cnt_t idx_last = beat_cnt_t'(`KD_NUM_QUERYS / 2 - 1);
    localparam beat_cnt_t dist_last = beat_cnt_t'(`KD_NUM_QUERYS - 1);
    localparam int addr_w = $bits(best_addr_t);

    beat_cnt_t word_cnt;
    beat_cnt_t word_last;
    logic      send_phase;
    logic      dist_phase;
    logic      issue;
    logic      rd;
    out_sel_e  sel_nxt;

    assign dist_phase = (phase == send_dist0) || (phase == send_dist1);
    assign send_phase = dist_phase || (phase == send_idx0) || (phase == send_idx1);
    assign word_last = dist_phase ? dist_last : idx_last;

    // full_n lags a write by one cycle, so wait out the previous enqueue
    assign issue = send_phase && !out_fifo_wenq && out_fifo_wfull_n;

    // high half of a distance is already in the FIFO data path
    assign rd = issue && !(dist_phase && word_cnt[0]);

    assign best_arr_csb1 = !rd;

    always_comb begin
        best_arr_addr1 = '0;
        if (rd) begin
            if (dist_phase) best_arr_addr1 = word_cnt[addr_w:1];
            else best_arr_addr1 = word_cnt[addr_w-1:0];
        end
    end

    always_comb begin
        case (phase)
            send_idx1:  sel_nxt = sel_idx1;
            send_dist0: sel_nxt = word_cnt[0] ? sel_dist_hi : sel_dist0;
            send_dist1: sel_nxt = word_cnt[0] ? sel_dist_hi : sel_dist1;
            default:    sel_nxt = sel_idx0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_fifo_wenq <= 1'b0;
            out_fifo_wdata_sel <= sel_idx0;
        end else begin
            out_fifo_wenq <= issue;
            out_fifo_wdata_sel <= sel_nxt;
        end
    end

    // word count moves with the enqueue, not the issue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (out_fifo_wenq) begin
            if (word_cnt == word_last) word_cnt <= '0;
            else word_cnt <= word_cnt + 1'b1;
        end
    end

    assign drain_seg_done = out_fifo_wenq && (word_cnt == word_last);

    a_no_back_to_back: assert property (@(posedge clk) disable iff (!rst_n)
        out_fifo_wenq |=> !out_fifo_wenq);

    a_read_when_room: assert property (@(posedge clk) disable iff (!rst_n)
        !best_arr_csb1 |-> out_fifo_wfull_n);

endmodule

//--- rtl/kd_load_execute.sv
`timescale 1ns/1ns
`include "kd_ctrl_cfg.svh"

module kd_load_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  kd_ctrl_pkg::kd_phase_e  phase,
    input  logic                    agg_receiver_enq,
    output logic                    agg_receiver_full_n,
    output logic                    int_node_fsm_enable,
    output kd_ctrl_pkg::leaf_lane_t leaf_mem_csb0,
    output kd_ctrl_pkg::leaf_lane_t leaf_mem_web0,
    output kd_ctrl_pkg::leaf_addr_t leaf_mem_addr0,
    output logic                    qp_mem_csb0,
    output logic                    qp_mem_web0,
    output kd_ctrl_pkg::qp_addr_t   qp_mem_addr0,
    output logic                    load_seg_done
);

    import kd_ctrl_pkg::*;

    localparam int lane_w = $clog2(`KD_LEAF_SIZE);
    localparam beat_cnt_t nodes_last = beat_cnt_t'(`KD_NUM_NODES - 1);
    localparam beat_cnt_t leaves_last = beat_cnt_t'(`KD_NUM_LEAVES * `KD_LEAF_SIZE - 1);
    localparam beat_cnt_t querys_last = beat_cnt_t'(`KD_NUM_QUERYS - 1);

    beat_cnt_t  beat_cnt;
    beat_cnt_t  beat_last;
    logic       load_phase;
    logic       accept;
    logic       leaf_wr;
    logic       qp_wr;
    leaf_lane_t lane_sel_n;

    assign load_phase = (phase == load_nodes) || (phase == load_leaves) ||
                        (phase == load_querys);

    // receiver is open for the whole of every load phase
    assign agg_receiver_full_n = load_phase;
    assign int_node_fsm_enable = (phase == load_nodes);
    assign accept = agg_receiver_enq && agg_receiver_full_n;

    always_comb begin
        case (phase)
            load_leaves: beat_last = leaves_last;
            load_querys: beat_last = querys_last;
            default:     beat_last = nodes_last;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (accept) begin
            if (beat_cnt == beat_last) beat_cnt <= '0;
            else beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign load_seg_done = accept && (beat_cnt == beat_last);

    // low bits of the beat pick the active-low lane select
    always_comb begin
        lane_sel_n = '1;
        lane_sel_n[beat_cnt[lane_w-1:0]] = 1'b0;
    end

    assign leaf_wr = accept && (phase == load_leaves);
    assign qp_wr = accept && (phase == load_querys);

    assign leaf_mem_csb0 = leaf_wr ? lane_sel_n : '1;
    assign leaf_mem_web0 = leaf_wr ? lane_sel_n : '1;
    assign leaf_mem_addr0 = leaf_wr ? beat_cnt[lane_w +: $bits(leaf_addr_t)] : '0;

    assign qp_mem_csb0 = !qp_wr;
    assign qp_mem_web0 = !qp_wr;
    assign qp_mem_addr0 = qp_wr ? beat_cnt[$bits(qp_addr_t)-1:0] : '0;

    a_one_lane: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(~leaf_mem_csb0));

    a_done_on_beat: assert property (@(posedge clk) disable iff (!rst_n)
        load_seg_done |-> (agg_receiver_enq && agg_receiver_full_n));

endmodule

//--- rtl/kd_phase_decode.sv
`timescale 1ns/1ns
`include "kd_ctrl_cfg.svh"

module kd_phase_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load_kdtree,
    input  logic                      send_best_arr,
    input  logic                      load_seg_done,
    input  logic                      drain_seg_done,
    output kd_ctrl_pkg::kd_phase_e    phase,
    output logic                      agg_change_fetch_width,
    output kd_ctrl_pkg::fetch_width_t agg_input_fetch_width
);

    import kd_ctrl_pkg::*;

    kd_phase_e phase_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= idle;
        end else begin
            phase <= phase_nxt;
        end
    end

    // width change is flagged in the cycle the load phase is decided
    always_comb begin
        phase_nxt = phase;
        agg_change_fetch_width = 1'b0;
        agg_input_fetch_width = '0;
        case (phase)
            idle: begin
                if (send_best_arr) begin
                    phase_nxt = send_idx0;
                end else if (load_kdtree) begin
                    phase_nxt = load_nodes;
                    agg_change_fetch_width = 1'b1;
                    agg_input_fetch_width = `KD_FW_NODES;
                end
            end
            load_nodes: begin
                if (load_seg_done) begin
                    phase_nxt = load_leaves;
                    agg_change_fetch_width = 1'b1;
                    agg_input_fetch_width = `KD_FW_LEAVES;
                end
            end
            load_leaves: begin
                if (load_seg_done) begin
                    phase_nxt = load_querys;
                    agg_change_fetch_width = 1'b1;
                    agg_input_fetch_width = `KD_FW_QUERYS;
                end
            end
            load_querys: begin
                if (load_seg_done) phase_nxt = idle;
            end
            send_idx0: begin
                if (drain_seg_done) phase_nxt = send_idx1;
            end
            send_idx1: begin
                if (drain_seg_done) phase_nxt = send_dist0;
            end
            send_dist0: begin
                if (drain_seg_done) phase_nxt = send_dist1;
            end
            send_dist1: begin
                if (drain_seg_done) phase_nxt = idle;
            end
            default: phase_nxt = idle;
        endcase
    end

    // segment completions come only from an active stream
    a_no_done_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (phase == idle) |-> !(load_seg_done || drain_seg_done));

endmodule

//--- rtl/kd_ctrl_pkg.sv
`include "kd_ctrl_cfg.svh"

package kd_ctrl_pkg;

    typedef enum logic [2:0] {
        idle,
        load_nodes,
        load_leaves,
        load_querys,
        send_idx0,
        send_idx1,
        send_dist0,
        send_dist1
    } kd_phase_e;

    // output FIFO data mux select
    typedef enum logic [2:0] {
        sel_idx0    = 3'd0,
        sel_idx1    = 3'd1,
        sel_dist0   = 3'd2,
        sel_dist1   = 3'd3,
        sel_dist_hi = 3'd4
    } out_sel_e;

    typedef logic [2:0] fetch_width_t;
    typedef logic [$clog2(`KD_NUM_LEAVES)-1:0] leaf_addr_t;
    typedef logic [`KD_LEAF_SIZE-1:0] leaf_lane_t;
    typedef logic [$clog2(`KD_NUM_QUERYS)-1:0] qp_addr_t;
    typedef logic [7:0] best_addr_t;
    typedef logic [15:0] beat_cnt_t;

endpackage

//--- rtl/kd_ctrl_cfg.svh
`ifndef KD_CTRL_CFG_SVH
`define KD_CTRL_CFG_SVH

// leaf memory geometry
`define KD_LEAF_SIZE 8
`define KD_NUM_LEAVES 64

// query grid
`define KD_ROW_SIZE 26
`define KD_COL_SIZE 19
`define KD_NUM_QUERYS (`KD_ROW_SIZE * `KD_COL_SIZE)

// a full binary tree over the leaves
`define KD_NUM_NODES (`KD_NUM_LEAVES - 1)

// aggregator fetch widths, one per load stream
`define KD_FW_NODES 3'd1
`define KD_FW_LEAVES 3'd5
`define KD_FW_QUERYS 3'd4

`endif
